// File: dv/dac_ctrl_tb.sv
`timescale 1ns/100ps

module dac_ctrl_tb import dac_pkg::*; ();

   logic                    DAC_CS;
   logic                    rst_n;
   logic                    wr;
   logic [num_channels-1:0] wr_mask;
   dac_value_t              wr_value;
   logic                    spi_sck;
   logic                    spi_mosi;
   logic                    spi_cs_n;
   logic                    dac_clr_n;
   // Test phase and directed expectations for the checker
   int                      test_id;
   logic                    exp_push;
   logic [3:0]              exp_addr;
   dac_value_t              exp_value;
   logic                    expect_quiet;
   logic                    final_check;
   int                      frame_cnt;
   int                      err_cnt;
   int                      timeouts;
   int                      gap;

   always #10 DAC_CS = ~DAC_CS;

   dac_ctrl_top dut (.*);

   dac_spi_checker u_checker (.*);

   task automatic reset_dut();
      repeat (5) @(posedge DAC_CS);
      rst_n <= 1'b1;
   endtask

   // One host write, strobe held for a single cycle
   task automatic host_write(input logic [num_channels-1:0] mask, input dac_value_t value);
      @(posedge DAC_CS);
      wr       <= 1'b1;
      wr_mask  <= mask;
      wr_value <= value;
      @(posedge DAC_CS);
      wr <= 1'b0;
   endtask

   // Frame the checker must see next
   task automatic push_expect(input logic [3:0] addr, input dac_value_t value);
      @(posedge DAC_CS);
      exp_push  <= 1'b1;
      exp_addr  <= addr;
      exp_value <= value;
      @(posedge DAC_CS);
      exp_push <= 1'b0;
   endtask

   task automatic set_phase(input int id, input logic quiet, input logic fin);
      @(posedge DAC_CS);
      test_id      <= id;
      expect_quiet <= quiet;
      final_check  <= fin;
   endtask

   task automatic wait_frames(input int target);
      int n;
      n = 0;
      while (frame_cnt < target && n < 2000) begin
         @(negedge DAC_CS);
         n++;
      end
      if (frame_cnt < target) begin
         $display("TIMEOUT: %0d of %0d frames seen", frame_cnt, target);
         timeouts++;
      end
   endtask

   task automatic wait_cs_low();
      int n;
      n = 0;
      while (spi_cs_n && n < 500) begin
         @(negedge DAC_CS);
         n++;
      end
      if (spi_cs_n) begin
         $display("TIMEOUT: spi_cs_n never fell");
         timeouts++;
      end
   endtask

   // Bus idle for a run of cycles longer than one frame
   task automatic wait_quiet(input int need);
      int n;
      int idle;
      n    = 0;
      idle = 0;
      while (idle < need && n < 6000) begin
         @(negedge DAC_CS);
         idle = spi_cs_n ? idle + 1 : 0;
         n++;
      end
      if (idle < need) begin
         $display("TIMEOUT: bus never went quiet");
         timeouts++;
      end
   endtask

   initial begin
      DAC_CS       = 1'b0;
      rst_n        = 1'b0;
      wr           = 1'b0;
      wr_mask      = '0;
      wr_value     = '0;
      test_id      = 0;
      exp_push     = 1'b0;
      exp_addr     = '0;
      exp_value    = '0;
      expect_quiet = 1'b0;
      final_check  = 1'b0;
      timeouts     = 0;
      void'($urandom(32'h476ce3d9));
      reset_dut();
      // B alone on an idle bus, then the same value again
      set_phase(1, 1'b0, 1'b0);
      push_expect(4'd1, 12'h5a3);
      host_write(4'b0010, 12'h5a3);
      wait_frames(1);
      set_phase(2, 1'b1, 1'b0);
      host_write(4'b0010, 12'h5a3);
      wait_quiet(300);
      // A goes out, B D and A queue up behind it
      set_phase(3, 1'b0, 1'b0);
      push_expect(4'd0, 12'h111);
      host_write(4'b0001, 12'h111);
      wait_cs_low();
      push_expect(4'd1, 12'h222);
      host_write(4'b0010, 12'h222);
      push_expect(4'd3, 12'h444);
      host_write(4'b1000, 12'h444);
      push_expect(4'd0, 12'h123);
      host_write(4'b0001, 12'h123);
      wait_frames(5);
      // One value on all four outputs
      set_phase(4, 1'b0, 1'b0);
      push_expect(addr_all, 12'h9c7);
      host_write(4'b1111, 12'h9c7);
      wait_frames(6);
      set_phase(4, 1'b1, 1'b0);
      wait_quiet(300);
      // Random writes land while frames are on the bus
      set_phase(5, 1'b0, 1'b0);
      for (int i = 0; i < 60; i++) begin
         host_write(num_channels'($urandom_range(0, 15)), value_bits'($urandom_range(0, 4095)));
         gap = $urandom_range(0, 40);
         repeat (gap) @(posedge DAC_CS);
      end
      wait_quiet(300);
      set_phase(5, 1'b0, 1'b1);
      set_phase(5, 1'b0, 1'b0);
      repeat (3) @(negedge DAC_CS);
      $display("Checker errors: %0d, timeouts: %0d", err_cnt, timeouts);
      if (err_cnt == 0 && timeouts == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: dv/dac_spi_checker.sv
`timescale 1ns/100ps

module dac_spi_checker import dac_pkg::*; (
   input  logic                    DAC_CS,
   input  logic                    rst_n,
   // Host port as the DUT sees it
   input  logic                    wr,
   input  logic [num_channels-1:0] wr_mask,
   input  dac_value_t              wr_value,
   // DAC pins
   input  logic                    spi_sck,
   input  logic                    spi_mosi,
   input  logic                    spi_cs_n,
   input  logic                    dac_clr_n,
   // Directed expectations from the testbench
   input  int                      test_id,
   input  logic                    exp_push,
   input  logic [3:0]              exp_addr,
   input  dac_value_t              exp_value,
   input  logic                    expect_quiet,
   input  logic                    final_check,
   output int                      frame_cnt,
   output int                      err_cnt
);

   localparam int log_depth = 512;

   // Host writes per channel, oldest first
   dac_value_t wr_log [num_channels][log_depth];
   int         log_len [num_channels];
   // Log position just past the last write matched by a frame
   int         match_pos [num_channels];
   // DAC contents per channel, zero after clear
   dac_value_t last_sent [num_channels];
   // Directed frames, address over value
   logic [15:0]           exp_q [$];
   logic [frame_bits-1:0] frame;
   int   bits;
   int   clr_low;
   logic clr_seen;
   logic prev_sck;
   logic prev_mosi;
   logic prev_cs_n;
   int   errors = 0;
   int   frames = 0;

   function automatic string test_name(input int id);
      case (id)
         0: return "clear_first";
         1: return "single_write";
         2: return "repeat_write";
         3: return "round_robin";
         4: return "broadcast";
         5: return "coalescing";
         default: return "unknown";
      endcase
   endfunction

   // Reference model: the DAC ends on the last value written, zero if none
   function automatic dac_value_t final_value(input int ch);
      if (log_len[ch] == 0) return '0;
      return wr_log[ch][log_len[ch] - 1];
   endfunction

   // Reference model: a frame may carry any later write, never an older one
   function automatic int accept_pos(input int ch, input dac_value_t v);
      for (int j = match_pos[ch]; j < log_len[ch]; j++) begin
         if (wr_log[ch][j] == v) return j;
      end
      return -1;
   endfunction

   task automatic report_mismatch(input string what, input int exp, input int act);
      $display("CHECK FAILED %s %s: expected %0h actual %0h",
               test_name(test_id), what, exp, act);
      errors++;
   endtask

   task automatic report_error(input string msg);
      $display("ERROR in %s: %s", test_name(test_id), msg);
      errors++;
   endtask

   task automatic decode_frame();
      logic [3:0]  cmd;
      logic [3:0]  addr;
      dac_value_t  value;
      logic [15:0] exp;
      int          pos;
      {cmd, addr, value} = frame[tail_bits +: 20];
      frames++;
      if (bits != frame_bits) report_mismatch("SCK edges per frame", frame_bits, bits);
      if (cmd != cmd_write_update) report_mismatch("command", int'(cmd_write_update), int'(cmd));
      if (int'(addr) >= num_channels && addr != addr_all) begin
         report_error($sformatf("address %0h is neither a channel nor broadcast", addr));
      end
      if (expect_quiet) begin
         report_error($sformatf("frame to address %0h value %0h where none was due", addr, value));
      end
      // Directed frames come in order
      if (exp_q.size() > 0) begin
         exp = exp_q.pop_front();
         if (addr != exp[15:12]) report_mismatch("address", int'(exp[15:12]), int'(addr));
         if (value != exp[11:0]) report_mismatch("value", int'(exp[11:0]), int'(value));
      end
      for (int ch = 0; ch < num_channels; ch++) begin
         if (addr == addr_all || int'(addr) == ch) begin
            pos = accept_pos(ch, value);
            if (pos < 0) begin
               report_mismatch($sformatf("channel %0d write order", ch),
                               int'(final_value(ch)), int'(value));
            end else begin
               match_pos[ch] = pos + 1;
            end
            last_sent[ch] = value;
         end
      end
   endtask

   task automatic check_final();
      if (!clr_seen) report_error("dac_clr_n never went high");
      if (exp_q.size() != 0) report_error($sformatf("%0d directed frames never came", exp_q.size()));
      for (int ch = 0; ch < num_channels; ch++) begin
         if (last_sent[ch] != final_value(ch)) begin
            report_mismatch($sformatf("channel %0d final value", ch),
                            int'(final_value(ch)), int'(last_sent[ch]));
         end
      end
   endtask

   always @(posedge DAC_CS) begin
      if (!rst_n) begin
         for (int ch = 0; ch < num_channels; ch++) begin
            log_len[ch]   = 0;
            match_pos[ch] = 0;
            last_sent[ch] = '0;
         end
         exp_q.delete();
         frame     = '0;
         bits      = 0;
         clr_low   = 0;
         clr_seen  = 1'b0;
         prev_sck  = 1'b0;
         prev_mosi = 1'b0;
         prev_cs_n = 1'b1;
      end else begin
         // Clear pulse length, and no frame while it lasts
         if (!clr_seen) begin
            if (!dac_clr_n) begin
               clr_low++;
            end else begin
               clr_seen = 1'b1;
               if (clr_low != clr_cycles) report_mismatch("clear length", clr_cycles, clr_low);
            end
            if (!spi_cs_n) report_error("spi_cs_n fell before dac_clr_n went high");
         end
         // Host write log
         for (int ch = 0; ch < num_channels; ch++) begin
            if (wr && wr_mask[ch]) begin
               if (log_len[ch] == log_depth) begin
                  report_error("write log overflow");
               end else begin
                  wr_log[ch][log_len[ch]] = wr_value;
                  log_len[ch]++;
               end
            end
         end
         if (exp_push) exp_q.push_back({exp_addr, exp_value});
         if (!spi_cs_n) begin
            if (prev_cs_n) begin
               frame = '0;
               bits  = 0;
            end
            // Device samples on rising SCK
            if (spi_sck && !prev_sck) begin
               frame = {frame[frame_bits-2:0], spi_mosi};
               bits++;
            end
            if (spi_sck && prev_sck && spi_mosi != prev_mosi) begin
               report_error("spi_mosi changed while spi_sck was high");
            end
         end
         // Rising CS ends the frame
         if (spi_cs_n && !prev_cs_n) decode_frame();
         if (final_check) check_final();
         prev_sck  = spi_sck;
         prev_mosi = spi_mosi;
         prev_cs_n = spi_cs_n;
      end
      frame_cnt <= frames;
      err_cnt   <= errors;
   end

endmodule

// File: flist.f
src/dac_pkg.sv
src/dac_channel_reg.sv
src/dac_bus_arbiter.sv
src/dac_frame_serializer.sv
src/dac_ctrl_top.sv
dv/dac_spi_checker.sv
dv/dac_ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the DAC controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/100ps -f flist.f --top-module dac_ctrl_tb -Mdir obj_dir
out=$(./obj_dir/Vdac_ctrl_tb)
echo "$out"
if echo "$out" | grep -qx "No errors"; then
   exit 0
fi
exit 1

// File: src/dac_bus_arbiter.sv
`timescale 1ns/100ps

module dac_bus_arbiter import dac_pkg::*; (
   input  logic                    DAC_CS,
   input  logic                    rst_n,
   input  chan_req_t               req [num_channels],
   input  logic                    busy,
   output logic [num_channels-1:0] grant,
   output logic                    start,
   output dac_word_t               word
);

   // Last channel sent on its own address
   chan_idx_t last_ptr;
   // Channel chosen by the rotation
   chan_idx_t pick;

   logic [num_channels-1:0] pend;
   logic                    any_pend;
   logic                    found;
   logic                    all_same;

   always_comb begin : scan
      chan_idx_t idx;
      found    = 1'b0;
      pick     = last_ptr;
      all_same = 1'b1;
      for (int i = 0; i < num_channels; i++) begin
         pend[i] = req[i].pending;
         // Broadcast only if every channel waits with one value
         if (!req[i].pending || (req[i].value != req[0].value)) begin
            all_same = 1'b0;
         end
      end
      // Search starts one past the last grant, A follows D
      for (int k = 1; k <= num_channels; k++) begin
         idx = chan_idx_t'(last_ptr + k);
         if (!found && pend[idx]) begin
            found = 1'b1;
            pick  = idx;
         end
      end
      any_pend = |pend;
   end

   // Grant, start and word share the cycle, so a peer retires
   // exactly the value the serializer loads
   always_comb begin
      start      = !busy && any_pend;
      grant      = '0;
      word.cmd   = cmd_write_update;
      word.addr  = {{(4 - chan_bits){1'b0}}, pick};
      // On a broadcast every channel holds this same value
      word.value = req[pick].value;
      if (all_same) begin
         word.addr = addr_all;
      end
      if (start) begin
         if (all_same) begin
            grant = '1;
         end else begin
            grant = num_channels'(1) << pick;
         end
      end
   end

   // Rotation pointer, reset points at D so A is searched first
   always_ff @(posedge DAC_CS) begin
      if (!rst_n) begin
         last_ptr <= chan_idx_t'(num_channels - 1);
      end else if (start && !all_same) begin
         last_ptr <= pick;
      end
   end

endmodule

// File: src/dac_channel_reg.sv
`timescale 1ns/100ps

module dac_channel_reg import dac_pkg::*; (
   input  logic       DAC_CS,
   input  logic       rst_n,
   input  logic       wr,
   input  dac_value_t wr_value,
   input  logic       grant,
   output chan_req_t  req
);

   // Request state
   logic       pending;
   dac_value_t pend_value;
   // Value the DAC holds for this channel, zero after clear
   dac_value_t last_value;

   // Write decision for this cycle
   dac_value_t ref_value;
   logic       keep;
   logic       take;

   always_comb begin
      // On a grant the pending value becomes what the DAC holds
      ref_value = grant ? pend_value : last_value;
      // Still pending after this cycle without a new write
      keep = pending && !grant;
      // Redundant writes are dropped only when nothing waits
      take = wr && (keep || (wr_value != ref_value));
   end

   always_ff @(posedge DAC_CS) begin
      if (!rst_n) begin
         pending    <= 1'b0;
         last_value <= '0;
      end else begin
         // Record what goes out on the bus
         if (grant) begin
            last_value <= pend_value;
         end
         // A write in the grant cycle keeps the request up
         if (take) begin
            pending <= 1'b1;
         end else if (grant) begin
            pending <= 1'b0;
         end
      end
   end

   // Latest value replaces any older pending one
   always_ff @(posedge DAC_CS) begin
      if (take) begin
         pend_value <= wr_value;
      end
   end

   assign req.pending = pending;
   assign req.value   = pend_value;

endmodule

// File: src/dac_ctrl_top.sv
`timescale 1ns/100ps

module dac_ctrl_top import dac_pkg::*; (
   input  logic                    DAC_CS,
   input  logic                    rst_n,
   input  logic                    wr,
   input  logic [num_channels-1:0] wr_mask,
   input  dac_value_t              wr_value,
   output logic                    spi_sck,
   output logic                    spi_mosi,
   output logic                    spi_cs_n,
   output logic                    dac_clr_n
);

   // Requests and grants between peers and arbiter
   chan_req_t               req [num_channels];
   logic [num_channels-1:0] grant;

   // Arbiter to serializer
   logic      start;
   logic      busy;
   dac_word_t word;

   // One peer per output, A at index 0
   generate
      for (genvar i = 0; i < num_channels; i++) begin : g_chan
         dac_channel_reg u_chan (
            .DAC_CS   (DAC_CS),
            .rst_n    (rst_n),
            .wr       (wr & wr_mask[i]),
            .wr_value (wr_value),
            .grant    (grant[i]),
            .req      (req[i])
         );
      end
   endgenerate

   dac_bus_arbiter u_arb (
      .DAC_CS (DAC_CS),
      .rst_n  (rst_n),
      .req    (req),
      .busy   (busy),
      .grant  (grant),
      .start  (start),
      .word   (word)
   );

   dac_frame_serializer u_ser (
      .DAC_CS    (DAC_CS),
      .rst_n     (rst_n),
      .start     (start),
      .word      (word),
      .busy      (busy),
      .spi_sck   (spi_sck),
      .spi_mosi  (spi_mosi),
      .spi_cs_n  (spi_cs_n),
      .dac_clr_n (dac_clr_n)
   );

endmodule

// File: src/dac_frame_serializer.sv
`timescale 1ns/100ps

module dac_frame_serializer import dac_pkg::*; (
   input  logic      DAC_CS,
   input  logic      rst_n,
   input  logic      start,
   input  dac_word_t word,
   output logic      busy,
   output logic      spi_sck,
   output logic      spi_mosi,
   output logic      spi_cs_n,
   output logic      dac_clr_n
);

   typedef enum logic [1:0] {
      st_clear,
      st_idle,
      st_shift,
      st_gap
   } state_t;

   state_t                   state;
   // Cycles within one SCK half period
   logic [half_cnt_bits-1:0] half_cnt;
   // Bits already sent in this frame
   logic [bit_cnt_bits-1:0]  bit_cnt;
   // Shared by the clear pulse and the CS gap
   logic [seq_cnt_bits-1:0]  seq_cnt;
   logic [frame_bits-1:0]    shreg;

   assign busy     = (state != st_idle);
   // MSB first, changes only on falling SCK
   assign spi_mosi = shreg[frame_bits-1];

   always_ff @(posedge DAC_CS) begin
      if (!rst_n) begin
         state     <= st_clear;
         half_cnt  <= '0;
         bit_cnt   <= '0;
         seq_cnt   <= '0;
         shreg     <= '0;
         spi_sck   <= 1'b0;
         spi_cs_n  <= 1'b1;
         dac_clr_n <= 1'b0;
      end else begin
         case (state)
            st_clear: begin
               // Hold the DAC in clear, then let the gap run out
               if (seq_cnt == seq_cnt_bits'(clr_cycles - 1)) begin
                  dac_clr_n <= 1'b1;
                  seq_cnt   <= seq_cnt_bits'(1);
                  state     <= st_gap;
               end else begin
                  seq_cnt <= seq_cnt + 1'b1;
               end
            end
            st_idle: begin
               if (start) begin
                  // Don't-care fields go out as zero
                  shreg    <= {lead_bits'(0), word, tail_bits'(0)};
                  half_cnt <= '0;
                  bit_cnt  <= '0;
                  spi_sck  <= 1'b0;
                  spi_cs_n <= 1'b0;
                  state    <= st_shift;
               end
            end
            st_shift: begin
               if (half_cnt == half_cnt_bits'(sck_half_cycles - 1)) begin
                  half_cnt <= '0;
                  spi_sck  <= ~spi_sck;
                  // Falling edge, bit done
                  if (spi_sck) begin
                     if (bit_cnt == bit_cnt_bits'(frame_bits - 1)) begin
                        seq_cnt <= '0;
                        state   <= st_gap;
                     end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        shreg   <= shreg << 1;
                     end
                  end
               end else begin
                  half_cnt <= half_cnt + 1'b1;
               end
            end
            st_gap: begin
               // CS rises one cycle after the last falling SCK
               spi_cs_n <= 1'b1;
               if (seq_cnt == seq_cnt_bits'(cs_gap_cycles)) begin
                  state <= st_idle;
               end else begin
                  seq_cnt <= seq_cnt + 1'b1;
               end
            end
            default: begin
               state <= st_clear;
            end
         endcase
      end
   end

endmodule

// File: src/dac_pkg.sv
package dac_pkg;

   // Channel count and set point width
   localparam int num_channels = 4;
   localparam int value_bits   = 12;
   localparam int chan_bits    = $clog2(num_channels);

   // Frame layout, MSB first
   // 8 don't-care, command, address, value, 4 don't-care
   localparam int frame_bits = 32;
   localparam int lead_bits  = 8;
   localparam int tail_bits  = 4;

   // Write to input register and update the output at once
   localparam logic [3:0] cmd_write_update = 4'b0011;
   // All four outputs take the same value
   localparam logic [3:0] addr_all = 4'b1111;

   // Bus timing in DAC_CS cycles
   localparam int sck_half_cycles = 2;
   localparam int clr_cycles      = 8;
   localparam int cs_gap_cycles   = 2;

   // Counter widths derived from the timing above
   localparam int half_cnt_bits = $clog2(sck_half_cycles + 1);
   localparam int seq_cnt_bits  = $clog2(clr_cycles + 1);
   localparam int bit_cnt_bits  = $clog2(frame_bits);

   typedef logic [value_bits-1:0] dac_value_t;
   typedef logic [chan_bits-1:0]  chan_idx_t;

   // One DAC word, sits between the don't-care fields of the frame
   typedef struct packed {
      logic [3:0] cmd;
      logic [3:0] addr;
      dac_value_t value;
   } dac_word_t;

   // Request from one channel peer
   typedef struct packed {
      logic       pending;
      dac_value_t value;
   } chan_req_t;

endpackage
